/* logic/floor_pkg.sv */
// Floor indices, button and light masks, and request stack sizing
package floor_pkg;

    ////////////////////////////////////////////////////////////
    // Building size
    ////////////////////////////////////////////////////////////

    // Panel floors 1 to 11 map to indices 0 to 10
    localparam int NUM_FLOORS = 11;

    // A lit floor is never pushed twice, so one slot per floor is enough
    localparam int STACK_DEPTH = 11;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [3:0] floor_t;

    // One bit per floor, bit 0 is floor 1
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Fill count and slot index of the request stack
    typedef logic [3:0] stack_ptr_t;

    // Car position after reset
    localparam floor_t GROUND_FLOOR = 4'd0;

endpackage

/* logic/car_pkg.sv */
// Car states and the travel and door timing of the elevator car
package car_pkg;

    ////////////////////////////////////////////////////////////
    // Car state machine
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CAR_STOPPED,
        CAR_UP,
        CAR_DOWN,
        CAR_DOORS,
        CAR_HALTED
    } car_state_t;

    ////////////////////////////////////////////////////////////
    // Timing, in clock cycles
    ////////////////////////////////////////////////////////////

    localparam int FLOOR_TRAVEL_CYCLES = 8;
    localparam int DOOR_DWELL_CYCLES   = 4;

    // Must hold the larger of the two loads
    typedef logic [3:0] timer_count_t;

endpackage

/* logic/request_stack.sv */
// Last-in, first-out store of the accepted floor requests
`timescale 1ns/100ps

module request_stack
    import floor_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  logic   clear,
    input  logic   push,
    input  logic   pop,
    input  floor_t push_floor,
    output floor_t top_floor,
    output logic   stack_empty
);

    floor_t     entries [STACK_DEPTH];
    stack_ptr_t fill;
    stack_ptr_t head;
    stack_ptr_t write_ptr;
    logic       do_pop;
    logic       do_push;

    assign stack_empty = (fill == '0);
    assign do_pop      = pop && !stack_empty;
    assign do_push     = push && (do_pop || (fill < stack_ptr_t'(STACK_DEPTH)));

    // A pop closes the gap first, so a push in the same cycle lands one slot lower
    assign write_ptr = do_pop ? fill - 1'b1 : fill;

    // Head is the floor the car works on
    // It is locked until served, and later pushes stack above it
    assign top_floor = stack_empty ? GROUND_FLOOR : entries[head];

    ////////////////////////////////////////////////////////////
    // Fill count and head slot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fill <= '0;
            head <= '0;
        end else if (clear) begin
            fill <= '0;
            head <= '0;
        end else if (do_pop && do_push) begin
            // The fresh push becomes the next job
            head <= fill - 1'b1;
        end else if (do_pop) begin
            fill <= fill - 1'b1;
            head <= (fill > 4'd1) ? fill - 4'd2 : '0;
        end else if (do_push) begin
            fill <= fill + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_pop) begin
            // Served entry leaves, newer ones slide down one slot
            for (int i = 0; i < STACK_DEPTH - 1; i++) begin
                if (stack_ptr_t'(i) >= head) begin
                    entries[i] <= entries[i + 1];
                end
            end
        end
        if (do_push && !clear) begin
            entries[write_ptr] <= push_floor;
        end
    end

endmodule

/* logic/request_lights.sv */
// Accepts panel and call presses, drives the button lights and pushes requests
`timescale 1ns/100ps

module request_lights
    import floor_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t panel_buttons,
    input  floor_mask_t call_buttons,
    input  floor_t      current_floor,
    input  logic        halted,
    input  logic        arrive,
    output floor_mask_t panel_lights,
    output floor_mask_t call_lights,
    output logic        push,
    output floor_t      push_floor
);

    floor_mask_t busy;
    floor_mask_t panel_ok;
    floor_mask_t call_ok;
    logic        panel_hit;
    logic        call_hit;
    floor_t      panel_pick;
    floor_t      call_pick;
    logic        accept;
    floor_t      pick;

    ////////////////////////////////////////////////////////////
    // Acceptance and priority
    ////////////////////////////////////////////////////////////

    // Floors already lit, and the one the car stands at, are refused
    always_comb begin
        for (int i = 0; i < NUM_FLOORS; i++) begin
            busy[i] = panel_lights[i] | call_lights[i] | (current_floor == floor_t'(i));
        end
        panel_ok = panel_buttons & ~busy;
        call_ok  = call_buttons & ~busy;
    end

    // Downward scan, the lowest pressed floor is kept last
    always_comb begin
        panel_hit  = 1'b0;
        call_hit   = 1'b0;
        panel_pick = GROUND_FLOOR;
        call_pick  = GROUND_FLOOR;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (panel_ok[i]) begin
                panel_hit  = 1'b1;
                panel_pick = floor_t'(i);
            end
            if (call_ok[i]) begin
                call_hit  = 1'b1;
                call_pick = floor_t'(i);
            end
        end
    end

    // One request per cycle, panel first
    assign accept = !halted && !arrive && (panel_hit || call_hit);
    assign pick   = panel_hit ? panel_pick : call_pick;

    ////////////////////////////////////////////////////////////
    // Lights and push
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_lights <= '0;
            call_lights  <= '0;
            push         <= 1'b0;
        end else if (halted) begin
            panel_lights <= '0;
            call_lights  <= '0;
            push         <= 1'b0;
        end else begin
            push <= accept;
            if (arrive) begin
                panel_lights[current_floor] <= 1'b0;
                call_lights[current_floor]  <= 1'b0;
            end
            if (accept && panel_hit) begin
                panel_lights[panel_pick] <= 1'b1;
            end else if (accept) begin
                call_lights[call_pick] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            push_floor <= pick;
        end
    end

endmodule

/* logic/travel_timer.sv */
// Down-counter for the time between floors and the door dwell time
`timescale 1ns/100ps

module travel_timer
    import car_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    input  logic start,
    input  logic dwell,
    output logic done
);

    timer_count_t count;

    // Start always reloads, even while a count is running
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (start) begin
            if (dwell) begin
                count <= timer_count_t'(DOOR_DWELL_CYCLES);
            end else begin
                count <= timer_count_t'(FLOOR_TRAVEL_CYCLES);
            end
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last cycle of the count
    // A start in that same cycle gives back-to-back periods
    assign done = (count == timer_count_t'(1));

endmodule

/* logic/car_fsm.sv */
// Car state machine that moves the car floor by floor and runs the doors
`timescale 1ns/100ps

module car_fsm
    import floor_pkg::*;
    import car_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  logic   power_switch,
    input  logic   emergency_button,
    input  logic   door_open_button,
    input  logic   door_close_button,
    input  floor_t top_floor,
    input  logic   stack_empty,
    input  logic   timer_done,
    output logic   timer_start,
    output logic   timer_dwell,
    output logic   halted,
    output logic   arrive,
    output floor_t current_floor,
    output logic   car_moving,
    output logic   car_up,
    output logic   door_open,
    output logic   door_open_allowed,
    output logic   door_close_allowed
);

    car_state_t state;
    car_state_t next_state;
    floor_t     target;
    floor_t     next_floor;
    logic       halt_req;
    logic       standing;

    assign halt_req = !power_switch || emergency_button;

    ////////////////////////////////////////////////////////////
    // Next state, floor step and timer control
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state  = state;
        next_floor  = current_floor;
        timer_start = 1'b0;
        timer_dwell = 1'b0;
        if (halt_req) begin
            next_state = CAR_HALTED;
        end else begin
            case (state)
                CAR_STOPPED: begin
                    if (!stack_empty) begin
                        timer_start = 1'b1;
                        if (top_floor > current_floor) begin
                            next_state = CAR_UP;
                        end else if (top_floor < current_floor) begin
                            next_state = CAR_DOWN;
                        end else begin
                            next_state  = CAR_DOORS;
                            timer_dwell = 1'b1;
                        end
                    end
                end
                CAR_UP, CAR_DOWN: begin
                    if (timer_done) begin
                        if (state == CAR_UP) begin
                            next_floor = current_floor + 1'b1;
                        end else begin
                            next_floor = current_floor - 1'b1;
                        end
                        // Next floor's run, or the dwell if this is the stop
                        timer_start = 1'b1;
                        if (next_floor == target) begin
                            next_state  = CAR_DOORS;
                            timer_dwell = 1'b1;
                        end
                    end
                end
                CAR_DOORS: begin
                    if (timer_done) begin
                        next_state = CAR_STOPPED;
                    end
                end
                CAR_HALTED: next_state = CAR_STOPPED;
                default:    next_state = CAR_STOPPED;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= CAR_STOPPED;
            current_floor <= GROUND_FLOOR;
            arrive        <= 1'b0;
        end else begin
            state         <= next_state;
            current_floor <= next_floor;
            // First cycle in CAR_DOORS
            arrive        <= (next_state == CAR_DOORS) && (state != CAR_DOORS);
        end
    end

    // Sampled on every stopped cycle, so it holds the value seen at departure
    always_ff @(posedge clock) begin
        if (state == CAR_STOPPED) begin
            target <= top_floor;
        end
    end

    ////////////////////////////////////////////////////////////
    // Status and door permissions
    ////////////////////////////////////////////////////////////

    assign halted     = (state == CAR_HALTED);
    assign car_moving = (state == CAR_UP) || (state == CAR_DOWN);
    assign car_up     = (state == CAR_UP);
    assign door_open  = (state == CAR_DOORS);

    // Power-off lands in CAR_HALTED, so it is covered here too
    assign standing           = (state == CAR_STOPPED) || (state == CAR_DOORS);
    assign door_open_allowed  = door_open_button && standing;
    assign door_close_allowed = door_close_button && standing;

endmodule

/* logic/elevator_top.sv */
// Elevator floor controller with request lights, request stack and car control
`timescale 1ns/100ps

module elevator_top
    import floor_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t panel_buttons,
    input  floor_mask_t call_buttons,
    input  logic        door_open_button,
    input  logic        door_close_button,
    input  logic        emergency_button,
    input  logic        power_switch,
    output floor_mask_t panel_lights,
    output floor_mask_t call_lights,
    output floor_t      current_floor,
    output logic        car_moving,
    output logic        car_up,
    output logic        door_open,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    // Car to timer
    logic   timer_start;
    logic   timer_dwell;
    logic   timer_done;

    // Car to lights and stack
    logic   halted;
    logic   arrive;

    // Lights to stack, and stack back to the car
    logic   push;
    floor_t push_floor;
    floor_t top_floor;
    logic   stack_empty;

    car_fsm u_car_fsm (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_button   (emergency_button),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .top_floor          (top_floor),
        .stack_empty        (stack_empty),
        .timer_done         (timer_done),
        .timer_start        (timer_start),
        .timer_dwell        (timer_dwell),
        .halted             (halted),
        .arrive             (arrive),
        .current_floor      (current_floor),
        .car_moving         (car_moving),
        .car_up             (car_up),
        .door_open          (door_open),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    travel_timer u_travel_timer (
        .clock   (clock),
        .reset_n (reset_n),
        .start   (timer_start),
        .dwell   (timer_dwell),
        .done    (timer_done)
    );

    request_stack u_request_stack (
        .clock       (clock),
        .reset_n     (reset_n),
        .clear       (halted),
        .push        (push),
        .pop         (arrive),
        .push_floor  (push_floor),
        .top_floor   (top_floor),
        .stack_empty (stack_empty)
    );

    request_lights u_request_lights (
        .clock         (clock),
        .reset_n       (reset_n),
        .panel_buttons (panel_buttons),
        .call_buttons  (call_buttons),
        .current_floor (current_floor),
        .halted        (halted),
        .arrive        (arrive),
        .panel_lights  (panel_lights),
        .call_lights   (call_lights),
        .push          (push),
        .push_floor    (push_floor)
    );

endmodule

/* verification/elevator_checker.sv */
// Concurrent assertions on car motion, floor range and light clearing
`timescale 1ns/100ps

module elevator_checker
    import floor_pkg::*;
(
    input logic        clock,
    input logic        reset_n,
    input logic        door_open,
    input logic        car_moving,
    input logic        halted,
    input floor_t      current_floor,
    input floor_mask_t panel_lights,
    input floor_mask_t call_lights
);

    // Count of failed assertions
    int failures = 0;

    door_vs_motion: assert property (@(posedge clock) disable iff (!reset_n)
        !(door_open && car_moving))
        else begin
            $error("doors open while the car moves");
            failures++;
        end

    floor_range: assert property (@(posedge clock) disable iff (!reset_n)
        current_floor < floor_t'(NUM_FLOORS))
        else begin
            $error("current floor out of range");
            failures++;
        end

    // Lights go dark one cycle into a halt
    halt_clears: assert property (@(posedge clock) disable iff (!reset_n)
        halted |=> (panel_lights == '0 && call_lights == '0))
        else begin
            $error("lights still on during halt");
            failures++;
        end

endmodule

bind elevator_top elevator_checker u_checker (
    .clock         (clock),
    .reset_n       (reset_n),
    .door_open     (door_open),
    .car_moving    (car_moving),
    .halted        (halted),
    .current_floor (current_floor),
    .panel_lights  (panel_lights),
    .call_lights   (call_lights)
);

/* verification/elevator_monitor.sv */
// Reference model of request acceptance and serving order, compared with the car outputs
`timescale 1ns/100ps

module elevator_monitor
    import floor_pkg::*;
    import car_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  floor_mask_t panel_buttons,
    input  floor_mask_t call_buttons,
    input  logic        door_open_button,
    input  logic        door_close_button,
    input  logic        emergency_button,
    input  logic        power_switch,
    input  floor_mask_t panel_lights,
    input  floor_mask_t call_lights,
    input  floor_t      current_floor,
    input  logic        car_moving,
    input  logic        car_up,
    input  logic        door_open,
    input  logic        door_open_allowed,
    input  logic        door_close_allowed,
    input  int          test_num,
    input  logic        test_done,
    input  logic        report,
    output int          total_errors,
    output int          failed_tests
);

    floor_mask_t exp_panel;
    floor_mask_t exp_call;
    floor_t      pending[$];
    int          job;
    logic        halt_m;
    logic        last_door;
    floor_t      last_floor;
    logic        last_up;
    logic        first_sample;
    int          step_cnt;
    int          dwell_cnt;
    int          test_errors;
    int          passed_tests;

    function automatic int lowest_floor(input floor_mask_t mask);
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (mask[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Lowest free panel press wins, else the lowest free call press
    function automatic int expected_pick(input floor_mask_t panel, input floor_mask_t call,
                                         input floor_mask_t blocked, output logic is_call);
        int p;
        int c;
        p = lowest_floor(panel & ~blocked);
        c = lowest_floor(call & ~blocked);
        is_call = (p < 0) && (c >= 0);
        return (p >= 0) ? p : c;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset state";
            2:       return "single request";
            3:       return "LIFO order";
            4:       return "refused presses";
            5:       return "emergency";
            default: return "door buttons and power";
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR %0t: test %0d: %s", $time, test_num, msg);
        test_errors++;
    endtask

    always @(posedge clock) begin : compare
        floor_mask_t blocked;
        logic        arrive_m;
        logic        is_call;
        int          pick;
        if (!reset_n) begin
            exp_panel    = '0;
            exp_call     = '0;
            pending.delete();
            job          = -1;
            halt_m       = 1'b0;
            last_door    = 1'b0;
            last_floor   = GROUND_FLOOR;
            last_up      = 1'b0;
            first_sample = 1'b1;
            step_cnt     = 0;
            dwell_cnt    = 0;
            test_errors  = 0;
            passed_tests = 0;
            total_errors = 0;
            failed_tests = 0;
        end else begin
            arrive_m = door_open && !last_door;
            if (first_sample && (current_floor != GROUND_FLOOR || door_open || car_moving)) begin
                report_error("car not at rest on the ground floor after reset");
            end
            first_sample = 1'b0;
            if (panel_lights !== exp_panel || call_lights !== exp_call) begin
                report_error($sformatf("lights panel %h call %h, expected %h %h",
                                       panel_lights, call_lights, exp_panel, exp_call));
            end
            if (door_open_allowed !== (door_open_button && !car_moving && !halt_m) ||
                door_close_allowed !== (door_close_button && !car_moving && !halt_m)) begin
                report_error("door permission does not follow the buttons");
            end
            if (halt_m && (car_moving || door_open)) begin
                report_error("car moves or opens while halted");
            end
            if (car_moving && job < 0) begin
                report_error("car moves with no request pending");
            end

            // Floor steps of one, one travel time apart
            if (current_floor != last_floor) begin
                if (current_floor != (last_up ? last_floor + 4'd1 : last_floor - 4'd1) ||
                    step_cnt != FLOOR_TRAVEL_CYCLES) begin
                    report_error($sformatf("floor %0d to %0d after %0d cycles",
                                           last_floor, current_floor, step_cnt));
                end
                step_cnt = 0;
            end
            step_cnt = car_moving ? step_cnt + 1 : 0;

            if (arrive_m) begin
                dwell_cnt = 0;
                if (job < 0) begin
                    report_error($sformatf("doors opened at floor %0d with no request",
                                           current_floor));
                end else begin
                    if (current_floor != floor_t'(job)) begin
                        report_error($sformatf("served floor %0d, expected %0d",
                                               current_floor, job));
                    end
                    exp_panel[job] = 1'b0;
                    exp_call[job]  = 1'b0;
                    for (int i = 0; i < pending.size(); i++) begin
                        if (pending[i] == floor_t'(job)) begin
                            pending.delete(i);
                            break;
                        end
                    end
                    job = (pending.size() > 0) ? int'(pending[pending.size() - 1]) : -1;
                end
            end
            if (door_open) begin
                dwell_cnt++;
            end else if (last_door && dwell_cnt != DOOR_DWELL_CYCLES) begin
                report_error($sformatf("doors open for %0d cycles", dwell_cnt));
            end

            if (halt_m) begin
                exp_panel = '0;
                exp_call  = '0;
                pending.delete();
                job = -1;
            end else if (!arrive_m) begin
                for (int i = 0; i < NUM_FLOORS; i++) begin
                    blocked[i] = exp_panel[i] | exp_call[i] | (current_floor == floor_t'(i));
                end
                pick = expected_pick(panel_buttons, call_buttons, blocked, is_call);
                if (pick >= 0) begin
                    if (is_call) begin
                        exp_call[pick] = 1'b1;
                    end else begin
                        exp_panel[pick] = 1'b1;
                    end
                    if (pending.size() == 0) begin
                        job = pick;
                    end
                    pending.push_back(floor_t'(pick));
                end
            end

            halt_m     = !power_switch || emergency_button;
            last_door  = door_open;
            last_floor = current_floor;
            last_up    = car_up;

            if (test_done) begin
                if (pending.size() != 0) begin
                    $display("Test %0d: floor %0d was requested but never served",
                             test_num, pending[0]);
                    test_errors++;
                end
                if (test_errors == 0) begin
                    $display("Test %0d (%s) passed", test_num, test_name(test_num));
                    passed_tests++;
                end else begin
                    $display("Test %0d (%s) failed with %0d errors",
                             test_num, test_name(test_num), test_errors);
                    failed_tests++;
                end
                total_errors += test_errors;
                test_errors = 0;
            end
            if (report) begin
                $display("Tests passed %0d, failed %0d, errors %0d",
                         passed_tests, failed_tests, total_errors);
            end
        end
    end

endmodule

/* verification/elevator_tb.sv */
// Testbench top for the elevator controller with clock, reset, stimulus and watchdog
`timescale 1ns/100ps

module elevator_tb
    import floor_pkg::*;
    import car_pkg::*;
;

    localparam int CLOCK_PERIOD = 40;
    localparam int SERVE_CYCLES = NUM_FLOORS * FLOOR_TRAVEL_CYCLES + DOOR_DWELL_CYCLES + 8;
    // Eight rides over all tests, doubled for margin
    localparam int WATCHDOG_CYCLES = 2 * 8 * SERVE_CYCLES + 200;

    logic        clock;
    logic        reset_n;
    floor_mask_t panel_buttons;
    floor_mask_t call_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency_button;
    logic        power_switch;
    floor_mask_t panel_lights;
    floor_mask_t call_lights;
    floor_t      current_floor;
    logic        car_moving;
    logic        car_up;
    logic        door_open;
    logic        door_open_allowed;
    logic        door_close_allowed;
    int          test_num;
    logic        test_done;
    logic        report;
    int          total_errors;
    int          failed_tests;
    int          wait_timeouts;
    logic [7:0]  lfsr_state;

    elevator_top u_dut (.*);

    elevator_monitor u_monitor (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Random floors
    ////////////////////////////////////////////////////////////

    // Taps 8, 6, 5, 4 for a maximal length sequence
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic random_floor(output floor_t f);
        int value;
        value = 0;
        for (int i = 0; i < 4; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        f = floor_t'(value % NUM_FLOORS);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic press(input floor_mask_t panel, input floor_mask_t call);
        @(posedge clock);
        panel_buttons <= panel;
        call_buttons  <= call;
        @(posedge clock);
        panel_buttons <= '0;
        call_buttons  <= '0;
    endtask

    // Waits until no light is on and the car rests with doors shut
    task automatic wait_idle(input int rides);
        int cycles;
        repeat (3) @(posedge clock);
        cycles = 0;
        while (cycles < rides * SERVE_CYCLES &&
               (panel_lights != '0 || call_lights != '0 || door_open || car_moving)) begin
            @(posedge clock);
            cycles++;
        end
        if (panel_lights != '0 || call_lights != '0 || door_open || car_moving) begin
            $display("Test %0d: the car did not come to rest in time", test_num);
            wait_timeouts++;
        end
    endtask

    task automatic wait_moving();
        int cycles;
        cycles = 0;
        while (!car_moving && cycles < 20) begin
            @(posedge clock);
            cycles++;
        end
        if (!car_moving) begin
            $display("Test %0d: the car did not start moving", test_num);
            wait_timeouts++;
        end
    endtask

    task automatic finish_test();
        @(posedge clock);
        test_done <= 1'b1;
        @(posedge clock);
        test_done <= 1'b0;
        test_num  <= test_num + 1;
    endtask

    // Random floor at least two floors away from the car
    task automatic far_floor(output floor_t f);
        random_floor(f);
        if (f + 4'd1 >= current_floor && f <= current_floor + 4'd1) begin
            f = (current_floor < 4'd5) ? floor_t'(NUM_FLOORS - 1) : GROUND_FLOOR;
        end
    endtask

    initial begin
        floor_t picks[4];
        floor_t f;
        logic   fresh;
        reset_n           = 1'b0;
        panel_buttons     = '0;
        call_buttons      = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency_button  = 1'b0;
        power_switch      = 1'b1;
        test_num          = 1;
        test_done         = 1'b0;
        report            = 1'b0;
        wait_timeouts     = 0;
        lfsr_state        = 8'd27;
        repeat (4) @(posedge clock);
        reset_n <= 1'b1;
        repeat (2) @(posedge clock);
        finish_test();

        // Single ride
        random_floor(f);
        if (f == current_floor) begin
            f = floor_t'(NUM_FLOORS - 1);
        end
        press(floor_mask_t'(1) << f, '0);
        wait_idle(1);
        finish_test();

        // Several floors pressed back to back
        for (int i = 0; i < 4; i++) begin
            fresh = 1'b0;
            while (!fresh) begin
                random_floor(f);
                fresh = (f != current_floor);
                for (int j = 0; j < i; j++) begin
                    if (picks[j] == f) begin
                        fresh = 1'b0;
                    end
                end
            end
            picks[i] = f;
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clock);
            panel_buttons <= floor_mask_t'(1) << picks[i];
        end
        @(posedge clock);
        panel_buttons <= '0;
        wait_idle(4);
        finish_test();

        // Own floor, same floor twice in one cycle, then a lit floor again
        press(floor_mask_t'(1) << current_floor, '0);
        repeat (2) @(posedge clock);
        far_floor(f);
        @(posedge clock);
        panel_buttons <= floor_mask_t'(1) << f;
        call_buttons  <= floor_mask_t'(1) << f;
        @(posedge clock);
        @(posedge clock);
        panel_buttons <= '0;
        call_buttons  <= '0;
        wait_idle(1);
        finish_test();

        // Emergency stop during a ride
        far_floor(f);
        press('0, floor_mask_t'(1) << f);
        wait_moving();
        repeat (FLOOR_TRAVEL_CYCLES + 2) @(posedge clock);
        emergency_button <= 1'b1;
        repeat (3) @(posedge clock);
        emergency_button <= 1'b0;
        repeat (3 * FLOOR_TRAVEL_CYCLES) @(posedge clock);
        finish_test();

        // Door buttons at rest, one at a time and together
        @(posedge clock);
        door_open_button  <= 1'b1;
        repeat (2) @(posedge clock);
        door_open_button  <= 1'b0;
        door_close_button <= 1'b1;
        repeat (2) @(posedge clock);
        door_open_button  <= 1'b1;
        repeat (3) @(posedge clock);

        // Then in motion and with power off
        far_floor(f);
        press(floor_mask_t'(1) << f, '0);
        wait_moving();
        repeat (4) @(posedge clock);
        power_switch <= 1'b0;
        repeat (3) @(posedge clock);
        power_switch      <= 1'b1;
        door_open_button  <= 1'b0;
        door_close_button <= 1'b0;
        wait_idle(1);
        finish_test();

        @(posedge clock);
        report <= 1'b1;
        @(posedge clock);
        report <= 1'b0;
        @(posedge clock);
        if (failed_tests == 0 && total_errors == 0 && wait_timeouts == 0 &&
            u_dut.u_checker.failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

/* list.f */
logic/floor_pkg.sv
logic/car_pkg.sv
logic/request_stack.sv
logic/request_lights.sv
logic/travel_timer.sv
logic/car_fsm.sv
logic/elevator_top.sv
verification/elevator_checker.sv
verification/elevator_monitor.sv
verification/elevator_tb.sv

/* Makefile */
# Verilator build and run of the elevator controller testbench

VERILATOR ?= verilator
TOP       ?= elevator_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	@status=0; ./$(BIN) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
